// File: llc_cfg_pkg.sv
/* cache geometry constants, credit counts, address and storage types,
   line state encoding */
package llc_cfg_pkg;

    // geometry
    localparam int LLC_WAYS       = 4;
    localparam int LLC_SET_BITS   = 4;
    localparam int LLC_SETS       = 1 << LLC_SET_BITS;
    localparam int LLC_TAG_BITS   = 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS      = 32;

    // flow control
    localparam int REQ_CREDITS    = 2;
    localparam int RSP_CREDITS    = 2;
    localparam int MEM_CREDITS    = 2;
    localparam int STAGE_DEPTH    = 2;
    localparam int SET_TABLE_SIZE = 4;

    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [1:0]              llc_way_t;
    typedef logic [1:0]              word_off_t;
    typedef logic [WORD_BITS-1:0]    word_t;

    // word 0 sits in the lowest bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // wide enough for counts up to 3
    typedef logic [1:0] credit_cnt_t;

    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_addr_t;

    typedef enum logic [1:0] {
        LINE_INVALID,
        LINE_CLEAN,
        LINE_DIRTY
    } llc_line_state_e;

endpackage

// File: llc_msg_pkg.sv
/* request, response and memory opcodes, channel messages,
   set view and stage queue item */
package llc_msg_pkg;

    import llc_cfg_pkg::*;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } llc_op_e;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // 47 bits
    typedef struct packed {
        llc_op_e    op;
        line_addr_t addr;
        word_off_t  off;
        word_t      data;
    } llc_req_t;

    // data is zero for writes
    typedef struct packed {
        llc_op_e op;
        word_t   data;
    } llc_rsp_t;

    // line only meaningful on MEM_WRITE
    typedef struct packed {
        mem_op_e    op;
        line_addr_t addr;
        line_t      line;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

    typedef struct packed {
        llc_tag_t        tag;
        llc_line_state_e state;
        line_t           line;
    } way_view_t;

    typedef struct packed {
        way_view_t [LLC_WAYS-1:0] ways;
        llc_way_t                 evict_ptr;
    } set_view_t;

    typedef struct packed {
        llc_req_t  req;
        set_view_t view;
    } stage_item_t;

endpackage

// File: llc_credit_queue.sv
/* circular FIFO that hands back one credit per popped entry */
module llc_credit_queue #(
    parameter int  DEPTH  = 2,
    parameter type item_t = logic
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  item_t push_data_i,
    output logic  valid_o,
    output item_t data_o,
    input  logic  pop_i,
    output logic  credit_o
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t               mem [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_pop;

    assign valid_o  = (count != '0);
    assign data_o   = mem[rd_ptr];
    assign do_pop   = pop_i && valid_o;
    // credit goes back in the cycle of the pop
    assign credit_o = do_pop;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

// File: llc_set_table.sv
/* table of sets with a request in flight, hazard check, add and remove */
module llc_set_table (
    input  logic                 clk,
    input  logic                 rst,
    input  llc_cfg_pkg::llc_set_t check_set_i,
    output logic                 hit_o,
    output logic                 full_o,
    input  logic                 add_i,
    input  logic                 remove_i,
    input  llc_cfg_pkg::llc_set_t remove_set_i
);

    import llc_cfg_pkg::*;

    logic [SET_TABLE_SIZE-1:0] valid;
    llc_set_t                  sets [SET_TABLE_SIZE];
    logic [SET_TABLE_SIZE-1:0] free_sel;

    // hazard check and first free entry
    always_comb begin
        hit_o    = 1'b0;
        free_sel = '0;
        for (int i = 0; i < SET_TABLE_SIZE; i++) begin
            if (valid[i] && sets[i] == check_set_i) begin
                hit_o = 1'b1;
            end
            if (!valid[i] && free_sel == '0) begin
                free_sel[i] = 1'b1;
            end
        end
    end

    assign full_o = &valid;

    // an add never lands on the entry being removed
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < SET_TABLE_SIZE; i++) begin
                if (remove_i && valid[i] && sets[i] == remove_set_i) begin
                    valid[i] <= 1'b0;
                end
                if (add_i && free_sel[i]) begin
                    valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SET_TABLE_SIZE; i++) begin
            if (add_i && free_sel[i]) begin
                sets[i] <= check_set_i;
            end
        end
    end

endmodule

// File: llc_tag_store.sv
/* tag, state and line arrays per set and way, eviction pointers,
   registered read port and one write port */
module llc_tag_store (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_en_i,
    input  llc_cfg_pkg::llc_set_t        rd_set_i,
    output llc_msg_pkg::set_view_t       rd_view_o,
    input  logic                        wr_en_i,
    input  llc_cfg_pkg::llc_set_t        wr_set_i,
    input  llc_cfg_pkg::llc_way_t        wr_way_i,
    input  llc_cfg_pkg::llc_tag_t        wr_tag_i,
    input  llc_cfg_pkg::llc_line_state_e wr_state_i,
    input  llc_cfg_pkg::line_t           wr_line_i,
    input  llc_cfg_pkg::llc_way_t        wr_evict_ptr_i
);

    import llc_cfg_pkg::*;

    llc_tag_t        tags      [LLC_SETS][LLC_WAYS];
    line_t           lines     [LLC_SETS][LLC_WAYS];
    llc_line_state_e states    [LLC_SETS][LLC_WAYS];
    llc_way_t        evict_ptr [LLC_SETS];

    // control state, cleared on reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
                for (int w = 0; w < LLC_WAYS; w++) begin
                    states[s][w] <= LINE_INVALID;
                end
            end
        end else if (wr_en_i) begin
            states[wr_set_i][wr_way_i] <= wr_state_i;
            evict_ptr[wr_set_i]        <= wr_evict_ptr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags[wr_set_i][wr_way_i]  <= wr_tag_i;
            lines[wr_set_i][wr_way_i] <= wr_line_i;
        end
    end

    // whole set comes out one cycle after the read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                rd_view_o.ways[w].tag   <= tags[rd_set_i][w];
                rd_view_o.ways[w].state <= states[rd_set_i][w];
                rd_view_o.ways[w].line  <= lines[rd_set_i][w];
            end
            rd_view_o.evict_ptr <= evict_ptr[rd_set_i];
        end
    end

endmodule

// File: llc_decoder.sv
/* input decode, set hazard stall, store read and stage queue push */
module llc_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid_i,
    input  llc_msg_pkg::llc_req_t    req_i,
    output logic                     req_pop_o,
    input  logic                     stage_credit_i,
    input  logic                     table_hit_i,
    input  logic                     table_full_i,
    output logic                     table_add_o,
    output logic                     rd_en_o,
    output llc_cfg_pkg::llc_set_t    rd_set_o,
    input  llc_msg_pkg::set_view_t   rd_view_i,
    output logic                     stage_push_o,
    output llc_msg_pkg::stage_item_t stage_item_o
);

    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    credit_cnt_t stage_credits;
    logic        pop;
    logic        issued_q;
    llc_req_t    issued_req_q;

    // stall on a busy set, a full table or no room downstream
    assign pop = req_valid_i && !table_hit_i && !table_full_i && (stage_credits != '0);

    assign req_pop_o   = pop;
    assign table_add_o = pop;
    assign rd_en_o     = pop;
    assign rd_set_o    = req_i.addr.set;

    // read data arrives now, pair it with last cycle's request
    assign stage_push_o      = issued_q;
    assign stage_item_o.req  = issued_req_q;
    assign stage_item_o.view = rd_view_i;

    // credit is spent at the pop, the push always follows
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stage_credits <= credit_cnt_t'(STAGE_DEPTH);
            issued_q      <= 1'b0;
        end else begin
            stage_credits <= stage_credits + credit_cnt_t'(stage_credit_i)
                             - credit_cnt_t'(pop);
            issued_q      <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issued_req_q <= req_i;
        end
    end

endmodule

// File: llc_process.sv
/* lookup, victim choice, writeback, fill, write merge, store update,
   set release and response */
module llc_process (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        item_valid_i,
    input  llc_msg_pkg::stage_item_t    item_i,
    output logic                        item_pop_o,
    output logic                        wr_en_o,
    output llc_cfg_pkg::llc_set_t        wr_set_o,
    output llc_cfg_pkg::llc_way_t        wr_way_o,
    output llc_cfg_pkg::llc_tag_t        wr_tag_o,
    output llc_cfg_pkg::llc_line_state_e wr_state_o,
    output llc_cfg_pkg::line_t           wr_line_o,
    output llc_cfg_pkg::llc_way_t        wr_evict_ptr_o,
    output logic                        table_remove_o,
    output llc_cfg_pkg::llc_set_t        remove_set_o,
    output logic                        mem_req_valid_o,
    output llc_msg_pkg::mem_req_t       mem_req_o,
    input  logic                        mem_credit_i,
    input  logic                        mem_rsp_valid_i,
    input  llc_msg_pkg::mem_rsp_t       mem_rsp_i,
    output logic                        rsp_valid_o,
    output llc_msg_pkg::llc_rsp_t       rsp_o,
    input  logic                        rsp_credit_i
);

    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    typedef enum logic [2:0] {
        LOOKUP,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } proc_state_e;

    proc_state_e     state;
    credit_cnt_t     mem_credits;
    credit_cnt_t     rsp_credits;
    llc_req_t        req;
    set_view_t       view;
    logic            hit;
    logic            all_valid;
    llc_way_t        hit_way;
    llc_way_t        victim_way;
    llc_way_t        way_q;
    llc_way_t        ptr_q;
    line_t           line_q;
    llc_line_state_e line_state_q;
    line_t           merged;

    // item stays at the queue head until RESPOND pops it
    assign req  = item_i.req;
    assign view = item_i.view;

    // lowest invalid way wins, else the eviction pointer
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        all_valid  = 1'b1;
        victim_way = view.evict_ptr;
        for (int w = LLC_WAYS - 1; w >= 0; w--) begin
            if (view.ways[w].state != LINE_INVALID && view.ways[w].tag == req.addr.tag) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
            if (view.ways[w].state == LINE_INVALID) begin
                all_valid  = 1'b0;
                victim_way = llc_way_t'(w);
            end
        end
    end

    assign mem_req_valid_o = (state == WRITEBACK || state == FILL_REQ) && (mem_credits != '0);
    assign rsp_valid_o     = (state == RESPOND) && (rsp_credits != '0);

    always_comb begin
        mem_req_o.op   = MEM_READ;
        mem_req_o.addr = req.addr;
        mem_req_o.line = '0;
        if (state == WRITEBACK) begin
            mem_req_o.op       = MEM_WRITE;
            mem_req_o.addr.tag = view.ways[way_q].tag;
            mem_req_o.line     = view.ways[way_q].line;
        end
    end

    always_comb begin
        merged = line_q;
        if (req.op == OP_WRITE) begin
            merged[req.off] = req.data;
        end
    end

    assign rsp_o.op   = req.op;
    assign rsp_o.data = (req.op == OP_READ) ? line_q[req.off] : '0;

    // store update, set release and pop go with the response
    assign item_pop_o     = rsp_valid_o;
    assign table_remove_o = rsp_valid_o;
    assign remove_set_o   = req.addr.set;
    assign wr_en_o        = rsp_valid_o;
    assign wr_set_o       = req.addr.set;
    assign wr_way_o       = way_q;
    assign wr_tag_o       = req.addr.tag;
    assign wr_state_o     = (req.op == OP_WRITE) ? LINE_DIRTY : line_state_q;
    assign wr_line_o      = merged;
    assign wr_evict_ptr_o = ptr_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= LOOKUP;
            mem_credits <= credit_cnt_t'(MEM_CREDITS);
            rsp_credits <= credit_cnt_t'(RSP_CREDITS);
        end else begin
            mem_credits <= mem_credits + credit_cnt_t'(mem_credit_i)
                           - credit_cnt_t'(mem_req_valid_o);
            rsp_credits <= rsp_credits + credit_cnt_t'(rsp_credit_i)
                           - credit_cnt_t'(rsp_valid_o);
            case (state)
                LOOKUP: begin
                    if (item_valid_i) begin
                        if (hit) begin
                            state <= RESPOND;
                        end else if (view.ways[victim_way].state == LINE_DIRTY) begin
                            state <= WRITEBACK;
                        end else begin
                            state <= FILL_REQ;
                        end
                    end
                end
                WRITEBACK: if (mem_req_valid_o) state <= FILL_REQ;
                FILL_REQ:  if (mem_req_valid_o) state <= FILL_WAIT;
                FILL_WAIT: if (mem_rsp_valid_i) state <= RESPOND;
                RESPOND:   if (rsp_valid_o) state <= LOOKUP;
                default:   state <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && item_valid_i) begin
            if (hit) begin
                way_q        <= hit_way;
                ptr_q        <= view.evict_ptr;
                line_q       <= view.ways[hit_way].line;
                line_state_q <= view.ways[hit_way].state;
            end else begin
                way_q <= victim_way;
                // pointer only moves when a valid line is evicted
                ptr_q <= all_valid ? view.evict_ptr + 1'b1 : view.evict_ptr;
            end
        end
        if (state == FILL_WAIT && mem_rsp_valid_i) begin
            line_q       <= mem_rsp_i.line;
            line_state_q <= LINE_CLEAN;
        end
    end

endmodule

// File: llc_core.sv
/* cache core top level, request and stage queues, decoder, set table,
   tag store and process stage */
module llc_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  llc_msg_pkg::llc_req_t req_i,
    output logic                  req_credit_o,
    output logic                  rsp_valid_o,
    output llc_msg_pkg::llc_rsp_t rsp_o,
    input  logic                  rsp_credit_i,
    output logic                  mem_req_valid_o,
    output llc_msg_pkg::mem_req_t mem_req_o,
    input  logic                  mem_credit_i,
    input  logic                  mem_rsp_valid_i,
    input  llc_msg_pkg::mem_rsp_t mem_rsp_i
);

    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    logic            req_q_valid;
    llc_req_t        req_q_data;
    logic            req_pop;
    logic            stage_push;
    stage_item_t     stage_item;
    logic            stage_valid;
    stage_item_t     stage_data;
    logic            stage_pop;
    logic            stage_credit;
    logic            table_hit;
    logic            table_full;
    logic            table_add;
    logic            table_remove;
    llc_set_t        remove_set;
    logic            rd_en;
    llc_set_t        rd_set;
    set_view_t       rd_view;
    logic            wr_en;
    llc_set_t        wr_set;
    llc_way_t        wr_way;
    llc_tag_t        wr_tag;
    llc_line_state_e wr_state;
    line_t           wr_line;
    llc_way_t        wr_evict_ptr;

    llc_credit_queue #(
        .DEPTH  (REQ_CREDITS),
        .item_t (llc_req_t)
    ) u_req_q (
        .clk         (clk),
        .rst         (rst),
        .push_i      (req_valid_i),
        .push_data_i (req_i),
        .valid_o     (req_q_valid),
        .data_o      (req_q_data),
        .pop_i       (req_pop),
        .credit_o    (req_credit_o)
    );

    llc_set_table u_set_table (
        .clk          (clk),
        .rst          (rst),
        .check_set_i  (req_q_data.addr.set),
        .hit_o        (table_hit),
        .full_o       (table_full),
        .add_i        (table_add),
        .remove_i     (table_remove),
        .remove_set_i (remove_set)
    );

    llc_decoder u_decoder (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_q_valid),
        .req_i          (req_q_data),
        .req_pop_o      (req_pop),
        .stage_credit_i (stage_credit),
        .table_hit_i    (table_hit),
        .table_full_i   (table_full),
        .table_add_o    (table_add),
        .rd_en_o        (rd_en),
        .rd_set_o       (rd_set),
        .rd_view_i      (rd_view),
        .stage_push_o   (stage_push),
        .stage_item_o   (stage_item)
    );

    llc_tag_store u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .rd_set_i       (rd_set),
        .rd_view_o      (rd_view),
        .wr_en_i        (wr_en),
        .wr_set_i       (wr_set),
        .wr_way_i       (wr_way),
        .wr_tag_i       (wr_tag),
        .wr_state_i     (wr_state),
        .wr_line_i      (wr_line),
        .wr_evict_ptr_i (wr_evict_ptr)
    );

    llc_credit_queue #(
        .DEPTH  (STAGE_DEPTH),
        .item_t (stage_item_t)
    ) u_stage_q (
        .clk         (clk),
        .rst         (rst),
        .push_i      (stage_push),
        .push_data_i (stage_item),
        .valid_o     (stage_valid),
        .data_o      (stage_data),
        .pop_i       (stage_pop),
        .credit_o    (stage_credit)
    );

    llc_process u_process (
        .clk             (clk),
        .rst             (rst),
        .item_valid_i    (stage_valid),
        .item_i          (stage_data),
        .item_pop_o      (stage_pop),
        .wr_en_o         (wr_en),
        .wr_set_o        (wr_set),
        .wr_way_o        (wr_way),
        .wr_tag_o        (wr_tag),
        .wr_state_o      (wr_state),
        .wr_line_o       (wr_line),
        .wr_evict_ptr_o  (wr_evict_ptr),
        .table_remove_o  (table_remove),
        .remove_set_o    (remove_set),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_credit_i    (mem_credit_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .rsp_credit_i    (rsp_credit_i)
    );

endmodule

// File: llc_core_chk.sv
/* assertions bound to llc_core, in-order shadow of expected responses,
   credit and memory request checks */
module llc_core_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  req_valid_i,
    input llc_msg_pkg::llc_req_t req_i,
    input logic                  req_credit_o,
    input logic                  rsp_valid_o,
    input llc_msg_pkg::llc_rsp_t rsp_o,
    input logic                  rsp_credit_i,
    input logic                  mem_req_valid_o,
    input llc_msg_pkg::mem_req_t mem_req_o,
    input logic                  mem_credit_i,
    input logic                  mem_rsp_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    // accepted requests in order, oldest unanswered at pend_rd
    llc_req_t       pend [64];
    logic [5:0]     pend_wr;
    logic [5:0]     pend_rd;
    // word shadow indexed by line address and offset
    word_t          shadow [1 << 14];
    logic [16383:0] written;
    logic           head_ok;
    llc_req_t       head;
    llc_rsp_t       exp_rsp;
    line_t          exp_line;
    int             rsp_left;
    int             mem_out;
    int             reqs_sent;
    int             creds_back;
    logic           seen_req;
    logic           fill_pend;
    int unsigned    fail_cnt = 0;

    // unwritten words follow the memory pattern
    function automatic word_t shadow_word(line_addr_t a, word_off_t o);
        logic [13:0] k;
        k = {a, o};
        return written[k] ? shadow[k] : {4'b0, a, 14'b0, o};
    endfunction

    always_comb begin
        head_ok      = (pend_wr != pend_rd);
        head         = pend[pend_rd];
        exp_rsp.op   = head.op;
        exp_rsp.data = (head.op == OP_READ) ? shadow_word(head.addr, head.off) : '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp_line[w] = shadow_word(mem_req_o.addr, word_off_t'(w));
        end
    end

    // writes take effect in the shadow when they are answered
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            pend_wr    <= '0;
            pend_rd    <= '0;
            written    <= '0;
            rsp_left   <= RSP_CREDITS;
            mem_out    <= 0;
            reqs_sent  <= 0;
            creds_back <= 0;
            seen_req   <= 1'b0;
            fill_pend  <= 1'b0;
        end else begin
            if (req_valid_i) begin
                pend[pend_wr] <= req_i;
                pend_wr       <= pend_wr + 6'd1;
                seen_req      <= 1'b1;
            end
            if (rsp_valid_o && head_ok) begin
                pend_rd <= pend_rd + 6'd1;
                if (head.op == OP_WRITE) begin
                    written[{head.addr, head.off}] <= 1'b1;
                    shadow[{head.addr, head.off}]  <= head.data;
                end
            end
            rsp_left   <= rsp_left + int'(rsp_credit_i) - int'(rsp_valid_o);
            mem_out    <= mem_out + int'(mem_req_valid_o) - int'(mem_credit_i);
            reqs_sent  <= reqs_sent + int'(req_valid_i);
            creds_back <= creds_back + int'(req_credit_o);
            if (mem_req_valid_o && mem_req_o.op == MEM_READ) begin
                fill_pend <= 1'b1;
            end else if (mem_rsp_valid_i) begin
                fill_pend <= 1'b0;
            end
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst)
        !seen_req |-> !rsp_valid_o && !mem_req_valid_o)
        else begin
            $error("response or memory request raised before any request");
            fail_cnt++;
        end

    a_rsp_pending: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o |-> head_ok)
        else begin
            $error("response came with no request pending");
            fail_cnt++;
        end

    a_rsp_value: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && head_ok |-> rsp_o == exp_rsp)
        else begin
            $error("[ERROR] rsp_o got %h expected %h", $sampled(rsp_o), $sampled(exp_rsp));
            fail_cnt++;
        end

    a_rsp_credit: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o |-> rsp_left > 0)
        else begin
            $error("response sent with no response credit left");
            fail_cnt++;
        end

    a_mem_credit: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o |-> mem_out < MEM_CREDITS)
        else begin
            $error("memory request sent beyond the memory credits");
            fail_cnt++;
        end

    a_req_credit: assert property (@(posedge clk) disable iff (!rst)
        req_credit_o |-> creds_back < reqs_sent)
        else begin
            $error("more request credits returned than requests sent");
            fail_cnt++;
        end

    // one fill per miss, always for the line in process
    a_fill: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && mem_req_o.op == MEM_READ |->
            head_ok && mem_req_o.addr == head.addr && !fill_pend)
        else begin
            $error("memory read for the wrong line or while a fill was pending");
            fail_cnt++;
        end

    a_writeback: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && mem_req_o.op == MEM_WRITE |-> mem_req_o.line == exp_line)
        else begin
            $error("[ERROR] mem_req_o.line got %h expected %h",
                   $sampled(mem_req_o.line), $sampled(exp_line));
            fail_cnt++;
        end

endmodule

bind llc_core llc_core_chk u_chk (.*);

// File: tb_llc.sv
/* testbench for llc_core: clock, reset, credit-aware requests,
   response credits and a backing memory model */
module tb_llc;
    timeunit 1ns;
    timeprecision 1ps;

    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    localparam int TIMEOUT = 4000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    llc_req_t   req;
    logic       req_credit;
    logic       rsp_valid;
    llc_rsp_t   rsp;
    logic       rsp_credit;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_credit;
    logic       mem_rsp_valid;
    mem_rsp_t   mem_rsp;

    int         seed = 86522;
    int         cycle = 0;
    int         req_sent = 0;
    int         req_ret = 0;
    int         rsp_cnt = 0;
    int         timeouts = 0;
    int         rsp_due [$];
    int         last_due = 0;
    line_t      mem_lines [logic [11:0]];
    logic [11:0] rd_addr;
    int         rd_timer = 0;

    llc_core u_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .req_credit_o    (req_credit),
        .rsp_valid_o     (rsp_valid),
        .rsp_o           (rsp),
        .rsp_credit_i    (rsp_credit),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_credit_i    (mem_credit),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_i       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // word w of a line never written: line address high, w low
    function automatic line_t pattern_line(logic [11:0] a);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = {4'b0, a, 16'(w)};
        end
        return l;
    endfunction

    function automatic line_t read_line(logic [11:0] a);
        return mem_lines.exists(a) ? mem_lines[a] : pattern_line(a);
    endfunction

    task automatic send_req(input llc_op_e op, input llc_tag_t tag, input llc_set_t set,
                            input word_off_t off, input word_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        while (req_sent - req_ret >= REQ_CREDITS && waited < TIMEOUT) begin
            req_valid <= 1'b0;
            waited++;
            @(posedge clk);
        end
        if (waited >= TIMEOUT) begin
            $display("timeout: no request credit came back");
            timeouts++;
        end else begin
            req_valid <= 1'b1;
            req       <= '{op: op, addr: '{tag: tag, set: set}, off: off, data: data};
            req_sent++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (rsp_cnt != req_sent && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rsp_cnt != req_sent) begin
            $display("timeout: only %0d of %0d responses arrived", rsp_cnt, req_sent);
            timeouts++;
        end
    endtask

    // request credits back, responses counted, response credits after a random delay
    always @(posedge clk) begin
        int due;
        cycle      <= cycle + 1;
        rsp_credit <= 1'b0;
        if (rst) begin
            if (req_credit) begin
                req_ret <= req_ret + 1;
            end
            if (rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1;
                due = cycle + 1 + {$random(seed)} % 6;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rsp_due.push_back(due);
            end
            if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
                rsp_credit <= 1'b1;
                void'(rsp_due.pop_front());
            end
        end
    end

    // backing memory, one read outstanding at most
    always @(posedge clk) begin
        mem_credit    <= 1'b0;
        mem_rsp_valid <= 1'b0;
        if (rst) begin
            if (rd_timer != 0) begin
                rd_timer = rd_timer - 1;
                if (rd_timer == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp.line  <= read_line(rd_addr);
                end
            end
            if (mem_req_valid) begin
                mem_credit <= 1'b1;
                if (mem_req.op == MEM_WRITE) begin
                    mem_lines[mem_req.addr] = mem_req.line;
                end else begin
                    rd_addr  = mem_req.addr;
                    rd_timer = 1 + {$random(seed)} % 8;
                end
            end
        end
    end

    initial begin
        llc_op_e op;
        int      errors;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        rsp_credit    = 1'b0;
        mem_credit    = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        // quiet window with no requests
        repeat (20) @(posedge clk);
        // cold miss
        send_req(OP_READ, 8'h11, 4'h3, 2'd2, '0);
        wait_drain();
        // write then read back to back in one set
        send_req(OP_WRITE, 8'h20, 4'h5, 2'd1, 32'hcafe_0001);
        send_req(OP_READ, 8'h20, 4'h5, 2'd1, '0);
        send_req(OP_WRITE, 8'h21, 4'h5, 2'd0, 32'h1234_5678);
        send_req(OP_READ, 8'h21, 4'h5, 2'd0, '0);
        wait_drain();
        // six lines into four ways forces dirty evictions
        for (int t = 0; t < 6; t++) begin
            send_req(OP_WRITE, llc_tag_t'(8'h40 + t), 4'h7, word_off_t'(t), 32'h600d_0000 + t);
        end
        for (int t = 0; t < 6; t++) begin
            send_req(OP_READ, llc_tag_t'(8'h40 + t), 4'h7, word_off_t'(t), '0);
        end
        wait_drain();
        // random mix over a few sets and more tags than ways
        for (int n = 0; n < 200; n++) begin
            op = ($random(seed) & 1) ? OP_WRITE : OP_READ;
            send_req(op, llc_tag_t'({$random(seed)} % 6), llc_set_t'({$random(seed)} % 4),
                     word_off_t'($random(seed)), $random(seed));
        end
        wait_drain();
        repeat (10) @(posedge clk);
        errors = timeouts + int'(u_dut.u_chk.fail_cnt);
        $display("requests %0d, responses %0d, timeouts %0d, assertion failures %0d",
                 req_sent, rsp_cnt, timeouts, u_dut.u_chk.fail_cnt);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
llc_cfg_pkg.sv
llc_msg_pkg.sv
llc_credit_queue.sv
llc_set_table.sv
llc_tag_store.sv
llc_decoder.sv
llc_process.sv
llc_core.sv
llc_core_chk.sv
tb_llc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_llc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
COMMON    ?= --timing --assert --timescale 1ns/1ps --top-module $(TOP)
BFLAGS    ?= --binary -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(BFLAGS) $(COMMON) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+$(ERR_LIMIT) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG)

lint:
	$(VERILATOR) --lint-only $(COMMON) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
